// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_sys_core
FILELIST  = vlog.f

.PHONY: sim clean

# Build, run, then look for the pass line in the simulator output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== hw/audio_mixer.sv ====
`timescale 1ns/10ps

module audio_mixer (
	input  logic               clk_sys,
	input  logic               resetd,
	input  sys_pkg::sample_t   i_audio_l,
	input  sys_pkg::sample_t   i_audio_r,
	input  logic               i_audio_s,
	input  logic [1:0]         i_audio_mix,
	input  sys_pkg::vol_att_t  i_vol_att,
	output sys_pkg::sample_t   o_audio_l,
	output sys_pkg::sample_t   o_audio_r
);

	sys_pkg::sample_t mix_l;
	sys_pkg::sample_t mix_r;
	logic             mix_s;

	// Sign-aware right shift
	function automatic sys_pkg::sample_t shr(
		input sys_pkg::sample_t v,
		input logic [3:0]       n,
		input logic             sgn
	);
		if (sgn) begin
			return sys_pkg::sample_t'($signed(v) >>> n);
		end
		return v >> n;
	endfunction

	// Blend part of the opposite channel into this one
	function automatic sys_pkg::sample_t cross_mix(
		input sys_pkg::sample_t own,
		input sys_pkg::sample_t other,
		input logic [1:0]       mode,
		input logic             sgn
	);
		case (mode)
			2'd1:    return own - shr(own, 4'd3, sgn) + shr(other, 4'd3, sgn);
			2'd2:    return own - shr(own, 4'd2, sgn) + shr(other, 4'd2, sgn);
			2'd3:    return shr(own, 4'd1, sgn) + shr(other, 4'd1, sgn);
			default: return own;
		endcase
	endfunction

	// =============================================================
	// Stage 1, cross-mix
	// =============================================================
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			mix_l <= '0;
			mix_r <= '0;
			mix_s <= 1'b0;
		end else begin
			mix_l <= cross_mix(i_audio_l, i_audio_r, i_audio_mix, i_audio_s);
			mix_r <= cross_mix(i_audio_r, i_audio_l, i_audio_mix, i_audio_s);
			mix_s <= i_audio_s;
		end
	end

	// =============================================================
	// Stage 2, attenuation and mute
	// =============================================================
	always_ff @(posedge clk_sys) begin
		if (resetd || i_vol_att[4]) begin
			o_audio_l <= '0;
			o_audio_r <= '0;
		end else begin
			o_audio_l <= shr(mix_l, i_vol_att[3:0], mix_s);
			o_audio_r <= shr(mix_r, i_vol_att[3:0], mix_s);
		end
	end

endmodule

// ==== hw/host_cmd_regs.sv ====
`timescale 1ns/10ps
`include "sys_defs.svh"

module host_cmd_regs (
	input  logic                 clk_sys,
	input  logic                 resetd,
	input  logic                 i_io_uio,
	input  logic                 i_io_strobe,
	input  sys_pkg::host_word_t  i_io_din,
	output sys_pkg::vid_dim_t    o_width,
	output sys_pkg::vid_dim_t    o_height,
	output sys_pkg::vid_dim_t    o_vset,
	output sys_pkg::vol_att_t    o_vol_att,
	output logic [7:0]           o_led_mask,
	output logic [7:0]           o_led_state
);

	sys_pkg::cmd_state_e state;
	sys_pkg::host_cmd_t  cmd;

	// Argument index within the current frame, stops at the timing word count
	logic [3:0] arg_cnt;
	logic       arg_cnt_full;

	assign arg_cnt_full = (arg_cnt >= 4'(`SYS_TIMING_WORDS));

	// =============================================================
	// Command decoder and settings
	// =============================================================
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state       <= sys_pkg::CMD_IDLE;
			cmd         <= '0;
			arg_cnt     <= '0;
			o_width     <= `SYS_DEF_WIDTH;
			o_height    <= `SYS_DEF_HEIGHT;
			o_vset      <= '0;
			o_vol_att   <= '0;
			o_led_mask  <= '0;
			o_led_state <= '0;
		end else if (!i_io_uio) begin
			// Frame closed, next strobe starts a new command
			state <= sys_pkg::CMD_IDLE;
		end else if (i_io_strobe) begin
			case (state)
				sys_pkg::CMD_IDLE: begin
					cmd     <= i_io_din[7:0];
					arg_cnt <= '0;
					state   <= sys_pkg::CMD_ARGS;
				end
				sys_pkg::CMD_ARGS: begin
					if (!arg_cnt_full) begin
						arg_cnt <= arg_cnt + 4'd1;
					end
					case (cmd)
						`SYS_CMD_TIMING: begin
							// Only the active size is kept, sync words pass by
							if (arg_cnt == 4'd0) begin
								o_width <= i_io_din[11:0];
							end
							if (arg_cnt == 4'd4) begin
								o_height <= i_io_din[11:0];
							end
						end
						`SYS_CMD_LED: begin
							o_led_mask  <= i_io_din[15:8];
							o_led_state <= i_io_din[7:0];
						end
						`SYS_CMD_VOLUME: begin
							o_vol_att <= i_io_din[4:0];
						end
						`SYS_CMD_VSET: begin
							o_vset <= i_io_din[11:0];
						end
						default: begin
							// Unknown command, words are swallowed
						end
					endcase
				end
			endcase
		end
	end

endmodule

// ==== hw/panel_io.sv ====
`timescale 1ns/10ps
`include "sys_defs.svh"

module panel_io #(
	parameter int DEBOUNCE_DIV = `SYS_DEB_DIV_DEFAULT
) (
	input  logic       clk_sys,
	input  logic       resetd,
	input  logic       i_btn_user_n,
	input  logic       i_btn_osd_n,
	input  logic       i_led_user,
	input  logic [1:0] i_led_power,
	input  logic [1:0] i_led_disk,
	input  logic [7:0] i_led_mask,
	input  logic [7:0] i_led_state,
	output logic       o_btn_user,
	output logic       o_btn_osd,
	output logic [7:0] o_led
);

	localparam int DIV_W = $clog2(DEBOUNCE_DIV + 2);

	logic [DIV_W-1:0]          div_cnt;
	logic                      tick;
	logic [`SYS_DEB_DEPTH-1:0] hist_user;
	logic [`SYS_DEB_DEPTH-1:0] hist_osd;
	logic                      led_pwr;
	logic [7:0]                led_status;

	// One sample tick every DEBOUNCE_DIV+1 clocks
	assign tick = (div_cnt == DIV_W'(DEBOUNCE_DIV));

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			div_cnt    <= '0;
			hist_user  <= '0;
			hist_osd   <= '0;
			o_btn_user <= 1'b0;
			o_btn_osd  <= 1'b0;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick) begin
				hist_user <= {hist_user[`SYS_DEB_DEPTH-2:0], ~i_btn_user_n};
				hist_osd  <= {hist_osd[`SYS_DEB_DEPTH-2:0], ~i_btn_osd_n};
				// Output moves only on a full run of equal samples
				if (&hist_user) o_btn_user <= 1'b1;
				if (~|hist_user) o_btn_user <= 1'b0;
				if (&hist_osd) o_btn_osd <= 1'b1;
				if (~|hist_osd) o_btn_osd <= 1'b0;
			end
		end
	end

	// Power light stays on unless the core takes it over
	assign led_pwr    = i_led_power[1] ? i_led_power[0] : 1'b1;
	assign led_status = {3'b000, led_pwr, 1'b0, i_led_disk[0], 1'b0, i_led_user};
	assign o_led      = (i_led_mask & i_led_state) | (~i_led_mask & led_status);

endmodule

// ==== hw/sys_core.sv ====
`timescale 1ns/10ps
`include "sys_defs.svh"

module sys_core #(
	parameter int DEBOUNCE_DIV = `SYS_DEB_DIV_DEFAULT
) (
	input  logic                 clk_sys,
	input  logic                 resetd,

	// Host bus
	input  logic                 i_io_uio,
	input  logic                 i_io_strobe,
	input  sys_pkg::host_word_t  i_io_din,

	// From the core
	input  sys_pkg::aspect_t     i_arx,
	input  sys_pkg::aspect_t     i_ary,
	input  sys_pkg::sample_t     i_audio_l,
	input  sys_pkg::sample_t     i_audio_r,
	input  logic                 i_audio_s,
	input  logic [1:0]           i_audio_mix,
	input  logic                 i_led_user,
	input  logic [1:0]           i_led_power,
	input  logic [1:0]           i_led_disk,
	input  logic                 i_btn_user_n,
	input  logic                 i_btn_osd_n,

	output sys_pkg::vid_dim_t    o_hmin,
	output sys_pkg::vid_dim_t    o_hmax,
	output sys_pkg::vid_dim_t    o_vmin,
	output sys_pkg::vid_dim_t    o_vmax,
	output sys_pkg::sample_t     o_audio_l,
	output sys_pkg::sample_t     o_audio_r,
	output logic                 o_btn_user,
	output logic                 o_btn_osd,
	output logic [7:0]           o_led
);

	sys_pkg::vid_dim_t width;
	sys_pkg::vid_dim_t height;
	sys_pkg::vid_dim_t vset;
	sys_pkg::vol_att_t vol_att;
	logic [7:0]        led_mask;
	logic [7:0]        led_state;

	host_cmd_regs i_host_cmd_regs (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_uio    (i_io_uio),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.o_width     (width),
		.o_height    (height),
		.o_vset      (vset),
		.o_vol_att   (vol_att),
		.o_led_mask  (led_mask),
		.o_led_state (led_state)
	);

	video_window i_video_window (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_width  (width),
		.i_height (height),
		.i_vset   (vset),
		.i_arx    (i_arx),
		.i_ary    (i_ary),
		.o_hmin   (o_hmin),
		.o_hmax   (o_hmax),
		.o_vmin   (o_vmin),
		.o_vmax   (o_vmax)
	);

	audio_mixer i_audio_mixer (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_audio_l   (i_audio_l),
		.i_audio_r   (i_audio_r),
		.i_audio_s   (i_audio_s),
		.i_audio_mix (i_audio_mix),
		.i_vol_att   (vol_att),
		.o_audio_l   (o_audio_l),
		.o_audio_r   (o_audio_r)
	);

	panel_io #(
		.DEBOUNCE_DIV (DEBOUNCE_DIV)
	) i_panel_io (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_btn_user_n (i_btn_user_n),
		.i_btn_osd_n  (i_btn_osd_n),
		.i_led_user   (i_led_user),
		.i_led_power  (i_led_power),
		.i_led_disk   (i_led_disk),
		.i_led_mask   (led_mask),
		.i_led_state  (led_state),
		.o_btn_user   (o_btn_user),
		.o_btn_osd    (o_btn_osd),
		.o_led        (o_led)
	);

endmodule

// ==== hw/sys_defs.svh ====
`ifndef SYS_DEFS_SVH
`define SYS_DEFS_SVH

// =============================================================
// Host command codes
// =============================================================
`define SYS_CMD_TIMING      8'h20
`define SYS_CMD_LED         8'h25
`define SYS_CMD_VOLUME      8'h26
`define SYS_CMD_VSET        8'h27

// =============================================================
// Output frame size out of reset
// =============================================================
`define SYS_DEF_WIDTH       12'd1920
`define SYS_DEF_HEIGHT      12'd1080

// Words carried by the timing command, later ones are dropped
`define SYS_TIMING_WORDS    8

// =============================================================
// Button debounce
// =============================================================
// Consecutive equal samples needed to change a button state
`define SYS_DEB_DEPTH       8
`define SYS_DEB_DIV_DEFAULT 100000

`endif

// ==== hw/sys_pkg.sv ====
package sys_pkg;

	// One word from the host bus
	typedef logic [15:0] host_word_t;

	// Command code, low byte of the first word of a frame
	typedef logic [7:0] host_cmd_t;

	// Pixel count, line count or screen coordinate
	typedef logic [11:0] vid_dim_t;

	// One term of the core's aspect ratio
	typedef logic [7:0] aspect_t;

	// Audio sample, signed or unsigned
	typedef logic [15:0] sample_t;

	// Bit 4 mutes, bits 3:0 give the right shift
	typedef logic [4:0] vol_att_t;

	// Host command decoder
	typedef enum logic {
		CMD_IDLE,
		CMD_ARGS
	} cmd_state_e;

endpackage

// ==== hw/video_window.sv ====
`timescale 1ns/10ps

module video_window (
	input  logic               clk_sys,
	input  logic               resetd,
	input  sys_pkg::vid_dim_t  i_width,
	input  sys_pkg::vid_dim_t  i_height,
	input  sys_pkg::vid_dim_t  i_vset,
	input  sys_pkg::aspect_t   i_arx,
	input  sys_pkg::aspect_t   i_ary,
	output sys_pkg::vid_dim_t  o_hmin,
	output sys_pkg::vid_dim_t  o_hmax,
	output sys_pkg::vid_dim_t  o_vmin,
	output sys_pkg::vid_dim_t  o_vmax
);

	logic [2:0]        step;
	logic              no_aspect;
	logic [19:0]       w_num;
	logic [19:0]       h_num;
	logic [19:0]       wcalc;
	logic [19:0]       hcalc;
	logic              clamp;
	sys_pkg::vid_dim_t videow;
	sys_pkg::vid_dim_t videoh;
	sys_pkg::vid_dim_t hoff;
	sys_pkg::vid_dim_t voff;

	assign no_aspect = (i_arx == '0) || (i_ary == '0);

	// Forced height takes over from the frame height
	assign w_num = {8'd0, (i_vset != '0) ? i_vset : i_height} * {12'd0, i_arx};
	assign h_num = {8'd0, i_width} * {12'd0, i_ary};

	// Centering offsets
	assign hoff = (i_width - videow) >> 1;
	assign voff = (i_height - videoh) >> 1;

	// Free-running sequencer gives the dividers several cycles to settle
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			step   <= '0;
			o_hmin <= '0;
			o_hmax <= '0;
			o_vmin <= '0;
			o_vmax <= '0;
		end else begin
			step <= step + 3'd1;
			if (step == 3'd7) begin
				o_hmin <= hoff;
				o_hmax <= hoff + videow - 12'd1;
				o_vmin <= voff;
				o_vmax <= voff + videoh - 12'd1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (step == 3'd0) begin
			clamp <= (i_vset == '0);
			wcalc <= no_aspect ? {8'd0, i_width} : w_num / {12'd0, i_ary};
			if (no_aspect) begin
				hcalc <= {8'd0, i_height};
			end else if (i_vset != '0) begin
				hcalc <= {8'd0, i_vset};
			end else begin
				hcalc <= h_num / {12'd0, i_arx};
			end
		end
		if (step == 3'd6) begin
			videow <= (clamp && (wcalc > {8'd0, i_width})) ? i_width : wcalc[11:0];
			videoh <= (clamp && (hcalc > {8'd0, i_height})) ? i_height : hcalc[11:0];
		end
	end

endmodule

// ==== verif/tb_sys_core.sv ====
`timescale 1ns/10ps
`include "sys_defs.svh"

module tb_sys_core;

	localparam int NWIN  = 7;
	localparam int NMIX  = 10;
	localparam int NSAMP = 6;

	// One host command, the core inputs and the window and LEDs it should give
	typedef struct packed {
		logic [7:0]   cmd;
		logic [3:0]   nwords;
		logic [159:0] words;
		logic [7:0]   arx;
		logic [7:0]   ary;
		// {led_user, led_power, led_disk}
		logic [4:0]   led_in;
		logic [11:0]  hmin;
		logic [11:0]  hmax;
		logic [11:0]  vmin;
		logic [11:0]  vmax;
		logic [7:0]   led;
	} win_entry_t;

	typedef struct packed {
		logic       sgn;
		logic [1:0] mix;
		logic [4:0] att;
	} mix_entry_t;

	logic                clk_sys;
	logic                resetd;
	logic                i_io_uio;
	logic                i_io_strobe;
	sys_pkg::host_word_t i_io_din;
	sys_pkg::aspect_t    i_arx;
	sys_pkg::aspect_t    i_ary;
	sys_pkg::sample_t    i_audio_l;
	sys_pkg::sample_t    i_audio_r;
	logic                i_audio_s;
	logic [1:0]          i_audio_mix;
	logic                i_led_user;
	logic [1:0]          i_led_power;
	logic [1:0]          i_led_disk;
	logic                i_btn_user_n;
	logic                i_btn_osd_n;
	sys_pkg::vid_dim_t   o_hmin;
	sys_pkg::vid_dim_t   o_hmax;
	sys_pkg::vid_dim_t   o_vmin;
	sys_pkg::vid_dim_t   o_vmax;
	sys_pkg::sample_t    o_audio_l;
	sys_pkg::sample_t    o_audio_r;
	logic                o_btn_user;
	logic                o_btn_osd;
	logic [7:0]          o_led;

	win_entry_t  win_tbl [NWIN];
	mix_entry_t  mix_tbl [NMIX];
	win_entry_t  e;
	mix_entry_t  m;
	logic [31:0] lfsr;
	logic [15:0] smp_l;
	logic [15:0] smp_r;
	logic [15:0] exp_l [NSAMP];
	logic [15:0] exp_r [NSAMP];
	logic        osd_seen;
	int          errors;
	int          tests;
	int          tests_failed;
	int          err_start;
	int          k;
	int          s;
	int          n;

	sys_core #(
		.DEBOUNCE_DIV (3)
	) i_sys_core (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_io_uio     (i_io_uio),
		.i_io_strobe  (i_io_strobe),
		.i_io_din     (i_io_din),
		.i_arx        (i_arx),
		.i_ary        (i_ary),
		.i_audio_l    (i_audio_l),
		.i_audio_r    (i_audio_r),
		.i_audio_s    (i_audio_s),
		.i_audio_mix  (i_audio_mix),
		.i_led_user   (i_led_user),
		.i_led_power  (i_led_power),
		.i_led_disk   (i_led_disk),
		.i_btn_user_n (i_btn_user_n),
		.i_btn_osd_n  (i_btn_osd_n),
		.o_hmin       (o_hmin),
		.o_hmax       (o_hmax),
		.o_vmin       (o_vmin),
		.o_vmax       (o_vmax),
		.o_audio_l    (o_audio_l),
		.o_audio_r    (o_audio_r),
		.o_btn_user   (o_btn_user),
		.o_btn_osd    (o_btn_osd),
		.o_led        (o_led)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// =============================================================
	// Stimulus tables
	// =============================================================
	task automatic load_tables;
		// Timing with junk sync words and two words past the end
		win_tbl[0] = '{`SYS_CMD_TIMING, 4'd10,
			{16'd1280, 16'h0abc, 16'hffff, 16'h1234, 16'd720,
			 16'h0555, 16'h7777, 16'h0001, 16'h0111, 16'h0222},
			8'd4, 8'd3, 5'b1_00_01, 12'd160, 12'd1119, 12'd0, 12'd719, 8'h15};
		// Forced height of 512 lines
		win_tbl[1] = '{`SYS_CMD_VSET, 4'd1, {16'd512, 144'd0},
			8'd4, 8'd3, 5'b1_00_01, 12'd299, 12'd980, 12'd104, 12'd615, 8'h15};
		win_tbl[2] = '{`SYS_CMD_VSET, 4'd1, {16'd0, 144'd0},
			8'd16, 8'd9, 5'b1_00_01, 12'd0, 12'd1279, 12'd0, 12'd719, 8'h15};
		win_tbl[3] = '{`SYS_CMD_TIMING, 4'd8,
			{16'd800, 16'h0fff, 16'h0fff, 16'h0fff, 16'd600,
			 16'h0fff, 16'h0fff, 16'h0fff, 32'd0},
			8'd16, 8'd9, 5'b1_00_01, 12'd0, 12'd799, 12'd75, 12'd524, 8'h15};
		// Unknown command with no aspect gives the full frame
		win_tbl[4] = '{8'h55, 4'd2, {16'h0fff, 16'h1234, 128'd0},
			8'd0, 8'd0, 5'b1_00_01, 12'd0, 12'd799, 12'd0, 12'd599, 8'h15};
		// Core turns the power light off and drives both disk bits
		win_tbl[5] = '{`SYS_CMD_LED, 4'd1, {16'hc3a1, 144'd0},
			8'd0, 8'd0, 5'b1_10_11, 12'd0, 12'd799, 12'd0, 12'd599, 8'h85};
		// No override with the user light off and the power light on
		win_tbl[6] = '{`SYS_CMD_LED, 4'd1, {16'h0000, 144'd0},
			8'd4, 8'd3, 5'b0_11_00, 12'd0, 12'd799, 12'd0, 12'd599, 8'h10};

		mix_tbl[0] = '{1'b0, 2'd0, 5'd0};
		mix_tbl[1] = '{1'b0, 2'd1, 5'd2};
		mix_tbl[2] = '{1'b0, 2'd2, 5'd0};
		mix_tbl[3] = '{1'b0, 2'd3, 5'd5};
		mix_tbl[4] = '{1'b1, 2'd0, 5'd1};
		mix_tbl[5] = '{1'b1, 2'd1, 5'd0};
		mix_tbl[6] = '{1'b1, 2'd2, 5'd3};
		mix_tbl[7] = '{1'b1, 2'd3, 5'd0};
		mix_tbl[8] = '{1'b1, 2'd1, 5'h13};
		mix_tbl[9] = '{1'b0, 2'd2, 5'd15};
	endtask

	// =============================================================
	// Host bus
	// =============================================================
	task automatic open_frame;
		@(negedge clk_sys);
		i_io_uio = 1'b1;
	endtask

	task automatic close_frame;
		@(negedge clk_sys);
		i_io_uio = 1'b0;
	endtask

	// One strobe cycle followed by one idle cycle
	task automatic strobe_word(input logic [15:0] w);
		@(negedge clk_sys);
		i_io_strobe = 1'b1;
		i_io_din    = w;
		@(negedge clk_sys);
		i_io_strobe = 1'b0;
	endtask

	// Word 0 sits in the top 16 bits
	task automatic send_cmd(input logic [7:0] cmd, input int nwords, input logic [159:0] words);
		int i;
		open_frame();
		strobe_word({8'h00, cmd});
		for (i = 0; i < nwords; i++) begin
			strobe_word(words[16*(9-i) +: 16]);
		end
		close_frame();
	endtask

	task automatic send_one(input logic [7:0] cmd, input logic [15:0] w);
		send_cmd(cmd, 1, {w, 144'd0});
	endtask

	// =============================================================
	// Reference models and random samples
	// =============================================================
	function automatic logic [31:0] lfsr_step(input logic [31:0] st);
		return {st[30:0], st[31] ^ st[21] ^ st[1] ^ st[0]};
	endfunction

	task automatic next_sample(output logic [15:0] v);
		int i;
		v = '0;
		for (i = 0; i < 16; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	// Shifts one bit at a time and copies the sign bit in when signed
	function automatic logic [15:0] shift_right(input logic [15:0] v, input int cnt,
		input logic sgn);
		logic [15:0] r;
		int          i;
		r = v;
		for (i = 0; i < cnt; i++) begin
			r = {sgn & r[15], r[15:1]};
		end
		return r;
	endfunction

	function automatic logic [15:0] expected_sample(input logic [15:0] own,
		input logic [15:0] other, input logic sgn, input logic [1:0] mix,
		input logic [4:0] att);
		logic [15:0] mixed;
		case (mix)
			2'd1: mixed = own - shift_right(own, 3, sgn) + shift_right(other, 3, sgn);
			2'd2: mixed = own - shift_right(own, 2, sgn) + shift_right(other, 2, sgn);
			2'd3: mixed = shift_right(own, 1, sgn) + shift_right(other, 1, sgn);
			default: mixed = own;
		endcase
		if (att[4]) begin
			return 16'd0;
		end
		return shift_right(mixed, int'(att[3:0]), sgn);
	endfunction

	// =============================================================
	// Checks and reporting
	// =============================================================
	task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp) else begin
			$display("** Error at %0t: %s expected 'h%h, got 'h%h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int first_err);
		tests++;
		if (errors == first_err) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d error(s)", name, errors - first_err);
		end
	endtask

	task automatic wait_for_btn(input logic osd, input logic level, input int limit);
		string name;
		int    i;
		bit    hit;
		hit = 1'b0;
		if (osd) begin
			name = "o_btn_osd";
		end else begin
			name = "o_btn_user";
		end
		for (i = 0; i < limit && !hit; i++) begin
			@(negedge clk_sys);
			hit = ((osd ? o_btn_osd : o_btn_user) == level);
		end
		assert (hit) else begin
			$display("Timeout: %s did not go to %0b within %0d cycles", name, level, limit);
			errors++;
		end
	endtask

	task automatic check_window(input win_entry_t x);
		check_val("o_hmin", 16'(o_hmin), 16'(x.hmin));
		check_val("o_hmax", 16'(o_hmax), 16'(x.hmax));
		check_val("o_vmin", 16'(o_vmin), 16'(x.vmin));
		check_val("o_vmax", 16'(o_vmax), 16'(x.vmax));
		check_val("o_led", 16'(o_led), 16'(x.led));
	endtask

	// =============================================================
	// Test sequence
	// =============================================================
	initial begin
		errors       = 0;
		tests        = 0;
		tests_failed = 0;
		lfsr         = 32'ha52efa29;
		resetd       = 1'b1;
		i_io_uio     = 1'b0;
		i_io_strobe  = 1'b0;
		i_io_din     = '0;
		i_arx        = '0;
		i_ary        = '0;
		i_audio_l    = '0;
		i_audio_r    = '0;
		i_audio_s    = 1'b0;
		i_audio_mix  = 2'd0;
		i_led_user   = 1'b1;
		i_led_power  = 2'b00;
		i_led_disk   = 2'b01;
		i_btn_user_n = 1'b1;
		i_btn_osd_n  = 1'b1;
		load_tables();

		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		resetd = 1'b0;

		// Defaults out of reset
		err_start = errors;
		check_val("o_audio_l", o_audio_l, 16'h0000);
		check_val("o_audio_r", o_audio_r, 16'h0000);
		check_val("o_btn_user", 16'(o_btn_user), 16'h0000);
		check_val("o_btn_osd", 16'(o_btn_osd), 16'h0000);
		repeat (16) @(negedge clk_sys);
		check_window(win_entry_t'{8'h00, 4'd0, 160'd0, 8'd0, 8'd0, 5'b1_00_01,
			12'd0, 12'd1919, 12'd0, 12'd1079, 8'h15});
		end_test("reset defaults", err_start);

		for (k = 0; k < NWIN; k++) begin
			err_start = errors;
			e = win_tbl[k];
			@(negedge clk_sys);
			i_arx = e.arx;
			i_ary = e.ary;
			{i_led_user, i_led_power, i_led_disk} = e.led_in;
			send_cmd(e.cmd, int'(e.nwords), e.words);
			// Window settles within 16 cycles of stable inputs
			repeat (16) @(negedge clk_sys);
			check_window(e);
			end_test($sformatf("command table %0d", k), err_start);
		end

		// Strays outside a frame and an unknown command cut short
		err_start = errors;
		strobe_word({8'h00, `SYS_CMD_LED});
		strobe_word(16'hff00);
		open_frame();
		strobe_word(16'h0055);
		strobe_word({8'h00, `SYS_CMD_LED});
		strobe_word(16'hff00);
		close_frame();
		repeat (2) @(negedge clk_sys);
		check_window(win_tbl[NWIN-1]);
		send_one(`SYS_CMD_LED, 16'hff00);
		@(negedge clk_sys);
		check_val("o_led", 16'(o_led), 16'h0000);
		send_one(`SYS_CMD_LED, 16'h0000);
		@(negedge clk_sys);
		check_val("o_led", 16'(o_led), 16'h0010);
		end_test("framing", err_start);

		for (k = 0; k < NMIX; k++) begin
			err_start = errors;
			m = mix_tbl[k];
			send_one(`SYS_CMD_VOLUME, {11'd0, m.att});
			i_audio_s   = m.sgn;
			i_audio_mix = m.mix;
			// New sample every cycle and each one checked two cycles later
			for (s = 0; s < NSAMP + 2; s++) begin
				@(negedge clk_sys);
				if (s >= 2) begin
					check_val("o_audio_l", o_audio_l, exp_l[s-2]);
					check_val("o_audio_r", o_audio_r, exp_r[s-2]);
				end
				if (s < NSAMP) begin
					next_sample(smp_l);
					next_sample(smp_r);
					i_audio_l = smp_l;
					i_audio_r = smp_r;
					exp_l[s]  = expected_sample(smp_l, smp_r, m.sgn, m.mix, m.att);
					exp_r[s]  = expected_sample(smp_r, smp_l, m.sgn, m.mix, m.att);
				end
			end
			end_test($sformatf("audio s=%0b mix=%0d att=%h", m.sgn, m.mix, m.att), err_start);
		end

		// Debounce with a sample tick every 4 cycles
		err_start = errors;
		osd_seen  = 1'b0;
		// One-cycle presses 5 cycles apart land on every tick phase
		for (n = 0; n < 4; n++) begin
			@(negedge clk_sys);
			i_btn_osd_n = 1'b0;
			@(negedge clk_sys);
			i_btn_osd_n = 1'b1;
			repeat (3) @(negedge clk_sys);
		end
		for (n = 0; n < 60; n++) begin
			@(negedge clk_sys);
			osd_seen = osd_seen | o_btn_osd;
		end
		assert (!osd_seen) else begin
			$display("o_btn_osd was set by a press shorter than one sample tick");
			errors++;
		end
		i_btn_user_n = 1'b0;
		wait_for_btn(1'b0, 1'b1, 100);
		i_btn_user_n = 1'b1;
		wait_for_btn(1'b0, 1'b0, 100);
		check_val("o_btn_osd", 16'(o_btn_osd), 16'h0000);
		i_btn_osd_n = 1'b0;
		wait_for_btn(1'b1, 1'b1, 100);
		i_btn_osd_n = 1'b1;
		wait_for_btn(1'b1, 1'b0, 100);
		check_val("o_btn_user", 16'(o_btn_user), 16'h0000);
		end_test("debounce", err_start);

		$display("%0d tests, %0d passed, %0d failed, %0d check errors",
			tests, tests - tests_failed, tests_failed, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/sys_pkg.sv
hw/host_cmd_regs.sv
hw/video_window.sv
hw/audio_mixer.sv
hw/panel_io.sv
hw/sys_core.sv
verif/tb_sys_core.sv
